// File: rtl/pkt_stream_pkg.sv
package pkt_stream_pkg;

   // beat payload
   localparam int DATA_W = 64;

   // unused bytes in the last beat of a packet, 0 to 7
   localparam int EMPTY_W = 3;

   // channel fan-out defaults
   localparam int NUM_CH = 4;
   localparam int FIFO_DEPTH = 16;   // beats per channel

   // The channel of a packet is named by the low CH_SEL_W bits of its
   // first data beat. The same bits route it through dispatch and merge.
   localparam int CH_SEL_W = 2;

endpackage

// File: rtl/stats_pkg.sv
package stats_pkg;

   // per-channel counters
   localparam int CNT_W = 32;

   // register bus
   localparam int AXI_ADDR_W = 8;
   localparam int AXI_DATA_W = 32;

   // Register map. Channel n owns an 8 byte window.
   //   n*8     packets drained from the channel FIFO
   //   n*8+4   beats drained from the channel FIFO
   localparam int REG_CH_STRIDE = 8;
   localparam int REG_PKT_OFS = 0;
   localparam int REG_BEAT_OFS = 4;

   // any write here clears every counter
   localparam logic [AXI_ADDR_W-1:0] REG_CLEAR = 8'h40;

   // response codes
   localparam logic [1:0] RESP_OKAY = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: rtl/pkt_dispatch.sv
`timescale 1ns/100ps

module pkt_dispatch #(
   parameter int NUM_CH = pkt_stream_pkg::NUM_CH,
   parameter int DATA_W = pkt_stream_pkg::DATA_W
) (
   input  logic                               clk,
   input  logic                               rst,

   input  logic                               in_valid_i,
   output logic                               in_ready_o,
   input  logic [DATA_W-1:0]                  in_data_i,
   input  logic                               in_sop_i,
   input  logic                               in_eop_i,
   input  logic [pkt_stream_pkg::EMPTY_W-1:0] in_empty_i,

   output logic [NUM_CH-1:0]                  ch_valid_o,
   input  logic [NUM_CH-1:0]                  ch_ready_i,
   output logic [DATA_W-1:0]                  ch_data_o,
   output logic                               ch_sop_o,
   output logic                               ch_eop_o,
   output logic [pkt_stream_pkg::EMPTY_W-1:0] ch_empty_o
);

   localparam int SEL_W = pkt_stream_pkg::CH_SEL_W;

   logic [SEL_W-1:0] cur_ch;   // channel of the packet in flight
   logic [SEL_W-1:0] sel_ch;
   logic             in_fire;

   // a sop beat names its own channel, later beats reuse the stored one
   assign sel_ch = in_sop_i ? in_data_i[SEL_W-1:0] : cur_ch;

   assign in_ready_o = ch_ready_i[sel_ch];   // no extra latency
   assign in_fire = in_valid_i && in_ready_o;

   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         ch_valid_o[i] = in_valid_i && (sel_ch == SEL_W'(i));
      end
   end

   // payload is shared, only valid is steered
   assign ch_data_o = in_data_i;
   assign ch_sop_o = in_sop_i;
   assign ch_eop_o = in_eop_i;
   assign ch_empty_o = in_empty_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         cur_ch <= '0;
      end else if (in_fire && in_sop_i) begin
         cur_ch <= sel_ch;   // held through eop
      end
   end

endmodule

// File: rtl/channel_fifo.sv
`timescale 1ns/100ps

module channel_fifo #(
   parameter int DATA_W = pkt_stream_pkg::DATA_W,
   parameter int FIFO_DEPTH = pkt_stream_pkg::FIFO_DEPTH
) (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               clear_i,

   input  logic                               wr_valid_i,
   output logic                               wr_ready_o,
   input  logic [DATA_W-1:0]                  wr_data_i,
   input  logic                               wr_sop_i,
   input  logic                               wr_eop_i,
   input  logic [pkt_stream_pkg::EMPTY_W-1:0] wr_empty_i,

   output logic                               rd_valid_o,
   input  logic                               rd_ready_i,
   output logic [DATA_W-1:0]                  rd_data_o,
   output logic                               rd_sop_o,
   output logic                               rd_eop_o,
   output logic [pkt_stream_pkg::EMPTY_W-1:0] rd_empty_o,

   output logic [stats_pkg::CNT_W-1:0]        pkt_cnt_o,
   output logic [stats_pkg::CNT_W-1:0]        beat_cnt_o
);

   localparam int EW = pkt_stream_pkg::EMPTY_W;
   localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int BEAT_W = DATA_W + EW + 2;
   localparam logic [AW:0] FILL_MAX = (AW + 1)'(FIFO_DEPTH);
   localparam logic [AW-1:0] PTR_LAST = AW'(FIFO_DEPTH - 1);

   logic [BEAT_W-1:0] mem [FIFO_DEPTH];
   logic [AW-1:0]     wr_ptr;
   logic [AW-1:0]     rd_ptr;
   logic [AW:0]       fill;   // beats held
   logic              wr_fire;
   logic              rd_fire;

   assign wr_ready_o = (fill != FILL_MAX);
   assign rd_valid_o = (fill != '0);
   assign wr_fire = wr_valid_i && wr_ready_o;
   assign rd_fire = rd_valid_o && rd_ready_i;

   // head of the buffer, a new beat shows up the cycle after its write
   assign {rd_sop_o, rd_eop_o, rd_empty_o, rd_data_o} = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_fire) begin
         mem[wr_ptr] <= {wr_sop_i, wr_eop_i, wr_empty_i, wr_data_i};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill <= '0;
      end else begin
         if (wr_fire) begin
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_fire) begin
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         end
         if (wr_fire && !rd_fire) begin
            fill <= fill + 1'b1;
         end else if (rd_fire && !wr_fire) begin
            fill <= fill - 1'b1;
         end
      end
   end

   // statistics on the drain side, saturating
   always_ff @(posedge clk) begin
      if (rst || clear_i) begin
         pkt_cnt_o <= '0;
         beat_cnt_o <= '0;
      end else if (rd_fire) begin
         if (beat_cnt_o != '1) begin
            beat_cnt_o <= beat_cnt_o + 1'b1;
         end
         if (rd_eop_o && (pkt_cnt_o != '1)) begin
            pkt_cnt_o <= pkt_cnt_o + 1'b1;   // one per packet
         end
      end
   end

endmodule

// File: rtl/pkt_merge.sv
`timescale 1ns/100ps

module pkt_merge #(
   parameter int NUM_CH = pkt_stream_pkg::NUM_CH,
   parameter int DATA_W = pkt_stream_pkg::DATA_W
) (
   input  logic                                      clk,
   input  logic                                      rst,

   input  logic [NUM_CH-1:0]                         ch_valid_i,
   output logic [NUM_CH-1:0]                         ch_ready_o,
   input  logic [NUM_CH*DATA_W-1:0]                  ch_data_i,
   input  logic [NUM_CH-1:0]                         ch_sop_i,
   input  logic [NUM_CH-1:0]                         ch_eop_i,
   input  logic [NUM_CH*pkt_stream_pkg::EMPTY_W-1:0] ch_empty_i,

   output logic                                      out_valid_o,
   input  logic                                      out_ready_i,
   output logic [DATA_W-1:0]                         out_data_o,
   output logic                                      out_sop_o,
   output logic                                      out_eop_o,
   output logic [pkt_stream_pkg::EMPTY_W-1:0]        out_empty_o
);

   localparam int EW = pkt_stream_pkg::EMPTY_W;
   localparam int SEL_W = pkt_stream_pkg::CH_SEL_W;
   localparam logic [SEL_W-1:0] LAST_CH = SEL_W'(NUM_CH - 1);

   logic [SEL_W-1:0] rr_ptr;    // first channel to look at
   logic [SEL_W-1:0] lock_ch;   // owner of the open packet
   logic             locked;
   logic [SEL_W-1:0] pick_ch;
   logic [SEL_W-1:0] sel_ch;
   logic             load_ok;
   logic             take;

   always_comb begin : rr_pick
      logic found;
      int   idx;
      found = 1'b0;
      pick_ch = rr_ptr;
      for (int k = 0; k < NUM_CH; k++) begin
         idx = (int'(rr_ptr) + k) % NUM_CH;
         if (!found && ch_valid_i[idx]) begin
            found = 1'b1;
            pick_ch = SEL_W'(idx);
         end
      end
   end

   assign sel_ch = locked ? lock_ch : pick_ch;
   assign load_ok = !out_valid_o || out_ready_i;   // output register free next edge
   assign take = load_ok && ch_valid_i[sel_ch];

   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         ch_ready_o[i] = load_ok && (sel_ch == SEL_W'(i));
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid_o <= 1'b0;
         locked <= 1'b0;
         lock_ch <= '0;
         rr_ptr <= '0;
      end else begin
         if (load_ok) begin
            out_valid_o <= ch_valid_i[sel_ch];
         end
         if (take && ch_eop_i[sel_ch]) begin
            locked <= 1'b0;
            rr_ptr <= (sel_ch == LAST_CH) ? '0 : sel_ch + 1'b1;   // pass the turn on
         end else if (take) begin
            locked <= 1'b1;
            lock_ch <= sel_ch;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         out_data_o <= ch_data_i[int'(sel_ch)*DATA_W +: DATA_W];
         out_sop_o <= ch_sop_i[sel_ch];
         out_eop_o <= ch_eop_i[sel_ch];
         out_empty_o <= ch_empty_i[int'(sel_ch)*EW +: EW];
      end
   end

endmodule

// File: rtl/stats_regs.sv
`timescale 1ns/100ps

module stats_regs #(
   parameter int NUM_CH = pkt_stream_pkg::NUM_CH
) (
   input  logic                                 clk,
   input  logic                                 rst,

   input  logic [NUM_CH*stats_pkg::CNT_W-1:0]   pkt_cnt_i,
   input  logic [NUM_CH*stats_pkg::CNT_W-1:0]   beat_cnt_i,
   output logic                                 clear_o,

   input  logic [stats_pkg::AXI_ADDR_W-1:0]     s_axi_awaddr_i,
   input  logic                                 s_axi_awvalid_i,
   output logic                                 s_axi_awready_o,
   input  logic [stats_pkg::AXI_DATA_W-1:0]     s_axi_wdata_i,
   input  logic                                 s_axi_wvalid_i,
   output logic                                 s_axi_wready_o,
   output logic [1:0]                           s_axi_bresp_o,
   output logic                                 s_axi_bvalid_o,
   input  logic                                 s_axi_bready_i,

   input  logic [stats_pkg::AXI_ADDR_W-1:0]     s_axi_araddr_i,
   input  logic                                 s_axi_arvalid_i,
   output logic                                 s_axi_arready_o,
   output logic [stats_pkg::AXI_DATA_W-1:0]     s_axi_rdata_o,
   output logic [1:0]                           s_axi_rresp_o,
   output logic                                 s_axi_rvalid_o,
   input  logic                                 s_axi_rready_i
);

   localparam int AW = stats_pkg::AXI_ADDR_W;
   localparam int DW = stats_pkg::AXI_DATA_W;
   localparam int CW = stats_pkg::CNT_W;
   localparam int STRIDE = stats_pkg::REG_CH_STRIDE;

   logic          wr_fire;
   logic          wr_clear;
   logic          rd_fire;
   logic          rd_hit;
   logic [DW-1:0] rd_word;

   // write side, address and data are taken in the same cycle
   assign s_axi_awready_o = s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_bvalid_o;
   assign s_axi_wready_o = s_axi_awready_o;
   assign wr_fire = s_axi_awready_o;
   assign wr_clear = (s_axi_awaddr_i == stats_pkg::REG_CLEAR);

   // the data word carries no meaning, only the address
   always_ff @(posedge clk) begin
      if (rst) begin
         s_axi_bvalid_o <= 1'b0;
         clear_o <= 1'b0;
      end else begin
         clear_o <= wr_fire && wr_clear;   // one cycle pulse
         if (wr_fire) begin
            s_axi_bvalid_o <= 1'b1;
         end else if (s_axi_bready_i) begin
            s_axi_bvalid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_fire) begin
         s_axi_bresp_o <= wr_clear ? stats_pkg::RESP_OKAY : stats_pkg::RESP_SLVERR;
      end
   end

   // read side, one outstanding response at a time
   assign s_axi_arready_o = !s_axi_rvalid_o;
   assign rd_fire = s_axi_arvalid_i && s_axi_arready_o;

   always_comb begin
      rd_hit = 1'b0;
      rd_word = '0;
      for (int n = 0; n < NUM_CH; n++) begin
         if (s_axi_araddr_i == AW'(n*STRIDE + stats_pkg::REG_PKT_OFS)) begin
            rd_hit = 1'b1;
            rd_word = DW'(pkt_cnt_i[n*CW +: CW]);
         end
         if (s_axi_araddr_i == AW'(n*STRIDE + stats_pkg::REG_BEAT_OFS)) begin
            rd_hit = 1'b1;
            rd_word = DW'(beat_cnt_i[n*CW +: CW]);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         s_axi_rvalid_o <= 1'b0;
      end else if (rd_fire) begin
         s_axi_rvalid_o <= 1'b1;
      end else if (s_axi_rready_i) begin
         s_axi_rvalid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_fire) begin
         s_axi_rdata_o <= rd_word;   // zero on a miss
         s_axi_rresp_o <= rd_hit ? stats_pkg::RESP_OKAY : stats_pkg::RESP_SLVERR;
      end
   end

endmodule

// File: rtl/pkt_stats_top.sv
`timescale 1ns/100ps

module pkt_stats_top #(
   parameter int NUM_CH = pkt_stream_pkg::NUM_CH,
   parameter int DATA_W = pkt_stream_pkg::DATA_W,
   parameter int FIFO_DEPTH = pkt_stream_pkg::FIFO_DEPTH
) (
   input  logic                               clk,
   input  logic                               rst,

   input  logic                               in_valid_i,
   output logic                               in_ready_o,
   input  logic [DATA_W-1:0]                  in_data_i,
   input  logic                               in_sop_i,
   input  logic                               in_eop_i,
   input  logic [pkt_stream_pkg::EMPTY_W-1:0] in_empty_i,

   output logic                               out_valid_o,
   input  logic                               out_ready_i,
   output logic [DATA_W-1:0]                  out_data_o,
   output logic                               out_sop_o,
   output logic                               out_eop_o,
   output logic [pkt_stream_pkg::EMPTY_W-1:0] out_empty_o,

   input  logic [stats_pkg::AXI_ADDR_W-1:0]   s_axi_awaddr_i,
   input  logic                               s_axi_awvalid_i,
   output logic                               s_axi_awready_o,
   input  logic [stats_pkg::AXI_DATA_W-1:0]   s_axi_wdata_i,
   input  logic                               s_axi_wvalid_i,
   output logic                               s_axi_wready_o,
   output logic [1:0]                         s_axi_bresp_o,
   output logic                               s_axi_bvalid_o,
   input  logic                               s_axi_bready_i,
   input  logic [stats_pkg::AXI_ADDR_W-1:0]   s_axi_araddr_i,
   input  logic                               s_axi_arvalid_i,
   output logic                               s_axi_arready_o,
   output logic [stats_pkg::AXI_DATA_W-1:0]   s_axi_rdata_o,
   output logic [1:0]                         s_axi_rresp_o,
   output logic                               s_axi_rvalid_o,
   input  logic                               s_axi_rready_i
);

   localparam int EW = pkt_stream_pkg::EMPTY_W;
   localparam int CW = stats_pkg::CNT_W;

   // dispatch to channels, payload shared
   logic [NUM_CH-1:0]      disp_valid;
   logic [NUM_CH-1:0]      disp_ready;
   logic [DATA_W-1:0]      disp_data;
   logic                   disp_sop;
   logic                   disp_eop;
   logic [EW-1:0]          disp_empty;

   // channels to merge, flattened per channel
   logic [NUM_CH-1:0]        ch_valid;
   logic [NUM_CH-1:0]        ch_ready;
   logic [NUM_CH*DATA_W-1:0] ch_data;
   logic [NUM_CH-1:0]        ch_sop;
   logic [NUM_CH-1:0]        ch_eop;
   logic [NUM_CH*EW-1:0]     ch_empty;

   logic [NUM_CH*CW-1:0]     pkt_cnt;
   logic [NUM_CH*CW-1:0]     beat_cnt;
   logic                     stats_clear;

   pkt_dispatch #(.NUM_CH(NUM_CH), .DATA_W(DATA_W)) u_dispatch (
      .clk(clk), .rst(rst),
      .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_data_i(in_data_i),
      .in_sop_i(in_sop_i), .in_eop_i(in_eop_i), .in_empty_i(in_empty_i),
      .ch_valid_o(disp_valid), .ch_ready_i(disp_ready), .ch_data_o(disp_data),
      .ch_sop_o(disp_sop), .ch_eop_o(disp_eop), .ch_empty_o(disp_empty)
   );

   for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
      channel_fifo #(.DATA_W(DATA_W), .FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
         .clk(clk), .rst(rst), .clear_i(stats_clear),
         .wr_valid_i(disp_valid[c]), .wr_ready_o(disp_ready[c]),
         .wr_data_i(disp_data), .wr_sop_i(disp_sop),
         .wr_eop_i(disp_eop), .wr_empty_i(disp_empty),
         .rd_valid_o(ch_valid[c]), .rd_ready_i(ch_ready[c]),
         .rd_data_o(ch_data[c*DATA_W +: DATA_W]), .rd_sop_o(ch_sop[c]),
         .rd_eop_o(ch_eop[c]), .rd_empty_o(ch_empty[c*EW +: EW]),
         .pkt_cnt_o(pkt_cnt[c*CW +: CW]), .beat_cnt_o(beat_cnt[c*CW +: CW])
      );
   end

   pkt_merge #(.NUM_CH(NUM_CH), .DATA_W(DATA_W)) u_merge (
      .clk(clk), .rst(rst),
      .ch_valid_i(ch_valid), .ch_ready_o(ch_ready), .ch_data_i(ch_data),
      .ch_sop_i(ch_sop), .ch_eop_i(ch_eop), .ch_empty_i(ch_empty),
      .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .out_data_o(out_data_o),
      .out_sop_o(out_sop_o), .out_eop_o(out_eop_o), .out_empty_o(out_empty_o)
   );

   stats_regs #(.NUM_CH(NUM_CH)) u_stats (
      .clk(clk), .rst(rst),
      .pkt_cnt_i(pkt_cnt), .beat_cnt_i(beat_cnt), .clear_o(stats_clear),
      .s_axi_awaddr_i(s_axi_awaddr_i), .s_axi_awvalid_i(s_axi_awvalid_i),
      .s_axi_awready_o(s_axi_awready_o),
      .s_axi_wdata_i(s_axi_wdata_i), .s_axi_wvalid_i(s_axi_wvalid_i),
      .s_axi_wready_o(s_axi_wready_o),
      .s_axi_bresp_o(s_axi_bresp_o), .s_axi_bvalid_o(s_axi_bvalid_o),
      .s_axi_bready_i(s_axi_bready_i),
      .s_axi_araddr_i(s_axi_araddr_i), .s_axi_arvalid_i(s_axi_arvalid_i),
      .s_axi_arready_o(s_axi_arready_o),
      .s_axi_rdata_o(s_axi_rdata_o), .s_axi_rresp_o(s_axi_rresp_o),
      .s_axi_rvalid_o(s_axi_rvalid_o), .s_axi_rready_i(s_axi_rready_i)
   );

endmodule

// File: dv/pkt_stats_checker.sv
`timescale 1ns/100ps

module pkt_stats_checker #(
   parameter int DATA_W = pkt_stream_pkg::DATA_W
) (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               strm_valid_i,
   input  logic                               strm_ready_i,
   input  logic [DATA_W-1:0]                  strm_data_i,
   input  logic                               strm_sop_i,
   input  logic                               strm_eop_i,
   input  logic [pkt_stream_pkg::EMPTY_W-1:0] strm_empty_i,
   input  logic                               rvalid_i,
   input  logic                               rready_i,
   input  logic                               bvalid_i,
   input  logic                               bready_i
);

   logic [DATA_W+pkt_stream_pkg::EMPTY_W+1:0] beat;
   int                                        fail_cnt = 0;   // failed assertions so far

   assign beat = {strm_sop_i, strm_eop_i, strm_empty_i, strm_data_i};

   // a stalled beat keeps valid and every field
   stream_hold: assert property (@(posedge clk) disable iff (rst)
      strm_valid_i && !strm_ready_i |=> strm_valid_i && $stable(beat))
      else begin
         fail_cnt++;
         $error("output beat changed while the stream was stalled");
      end

   read_hold: assert property (@(posedge clk) disable iff (rst)
      rvalid_i && !rready_i |=> rvalid_i)
      else begin
         fail_cnt++;
         $error("rvalid dropped before rready");
      end

   write_hold: assert property (@(posedge clk) disable iff (rst)
      bvalid_i && !bready_i |=> bvalid_i)
      else begin
         fail_cnt++;
         $error("bvalid dropped before bready");
      end

endmodule

// File: dv/tb_pkt_stats.sv
`timescale 1ns/100ps

module tb_pkt_stats;

   localparam int DATA_W = pkt_stream_pkg::DATA_W;
   localparam int EW = pkt_stream_pkg::EMPTY_W;
   localparam int NUM_CH = pkt_stream_pkg::NUM_CH;
   localparam int SEL_W = pkt_stream_pkg::CH_SEL_W;
   localparam int CW = stats_pkg::CNT_W;
   localparam int AW = stats_pkg::AXI_ADDR_W;
   localparam int DW = stats_pkg::AXI_DATA_W;
   localparam int REC_W = DATA_W + 12;   // sop, eop and empty nibbles above the data
   localparam int CNT_BASE = 'h30;       // expected counts in the data file
   localparam int TIMEOUT = 2000;        // cycles allowed per wait
   localparam logic [AW-1:0] UNMAPPED = 8'h80;

   logic              clk;
   logic              rst;
   logic              in_valid;
   logic              in_ready;
   logic [DATA_W-1:0] in_data;
   logic              in_sop;
   logic              in_eop;
   logic [EW-1:0]     in_empty;
   logic              out_valid;
   logic              out_ready;
   logic [DATA_W-1:0] out_data;
   logic              out_sop;
   logic              out_eop;
   logic [EW-1:0]     out_empty;
   logic [AW-1:0]     awaddr;
   logic              awvalid;
   logic              awready;
   logic [DW-1:0]     wdata;
   logic              wvalid;
   logic              wready;
   logic [1:0]        bresp;
   logic              bvalid;
   logic              bready;
   logic [AW-1:0]     araddr;
   logic              arvalid;
   logic              arready;
   logic [DW-1:0]     rdata;
   logic [1:0]        rresp;
   logic              rvalid;
   logic              rready;

   logic [REC_W-1:0]  testdata [0:63];
   logic [REC_W-1:0]  exp_q [NUM_CH][$];   // beats still owed per channel
   integer            seed;
   int                num_beats;
   int                beats_sent;
   int                beats_rcvd;
   int                err_value;
   int                err_other;
   logic [DW-1:0]     rd_data;
   logic [1:0]        resp;

   pkt_stats_top uut (
      .clk(clk), .rst(rst),
      .in_valid_i(in_valid), .in_ready_o(in_ready), .in_data_i(in_data),
      .in_sop_i(in_sop), .in_eop_i(in_eop), .in_empty_i(in_empty),
      .out_valid_o(out_valid), .out_ready_i(out_ready), .out_data_o(out_data),
      .out_sop_o(out_sop), .out_eop_o(out_eop), .out_empty_o(out_empty),
      .s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
      .s_axi_wdata_i(wdata), .s_axi_wvalid_i(wvalid), .s_axi_wready_o(wready),
      .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid), .s_axi_bready_i(bready),
      .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid), .s_axi_arready_o(arready),
      .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp), .s_axi_rvalid_o(rvalid),
      .s_axi_rready_i(rready)
   );

   bind pkt_stats_top pkt_stats_checker #(.DATA_W(DATA_W)) u_checker (
      .clk(clk), .rst(rst),
      .strm_valid_i(out_valid_o), .strm_ready_i(out_ready_i), .strm_data_i(out_data_o),
      .strm_sop_i(out_sop_o), .strm_eop_i(out_eop_o), .strm_empty_i(out_empty_o),
      .rvalid_i(s_axi_rvalid_o), .rready_i(s_axi_rready_i),
      .bvalid_i(s_axi_bvalid_o), .bready_i(s_axi_bready_i)
   );

   always #50 clk = ~clk;

   // output back-pressure low about one cycle in four
   always @(posedge clk) begin
      out_ready <= (($random(seed) & 32'h3) != 0);
   end

   task finish_run();
      int err_assert;
      err_assert = uut.u_checker.fail_cnt;
      $display("beats sent %0d, received %0d, value errors %0d, other errors %0d, assertions %0d",
               beats_sent, beats_rcvd, err_value, err_other, err_assert);
      if (err_value + err_other + err_assert == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   endtask

   task report_timeout(input string what);
      err_other++;
      $display("timeout while waiting for %s", what);
      finish_run();
   endtask

   task check_beat(input string name,
                   input logic [DATA_W-1:0] exp_data, input logic exp_sop,
                   input logic exp_eop, input logic [EW-1:0] exp_empty,
                   input logic [DATA_W-1:0] act_data, input logic act_sop,
                   input logic act_eop, input logic [EW-1:0] act_empty);
      if ({exp_sop, exp_eop, exp_empty, exp_data} !==
          {act_sop, act_eop, act_empty, act_data}) begin
         err_value++;
         $display("** Error: %s expected sop/eop/empty/data %b/%b/%0d/%h actual %b/%b/%0d/%h",
                  name, exp_sop, exp_eop, exp_empty, exp_data,
                  act_sop, act_eop, act_empty, act_data);
      end
   endtask

   task check_count(input string name, input logic [CW-1:0] expected,
                    input logic [CW-1:0] actual);
      if (expected !== actual) begin
         err_value++;
         $display("** Error: %s expected %0d actual %0d", name, expected, actual);
      end
   endtask

   task check_resp(input string name, input logic [1:0] expected, input logic [1:0] actual);
      if (expected !== actual) begin
         err_value++;
         $display("** Error: %s expected resp %b actual %b", name, expected, actual);
      end
   endtask

   task axi_read(input logic [AW-1:0] addr, output logic [DW-1:0] data,
                 output logic [1:0] rsp);
      int n;
      @(posedge clk);
      araddr <= addr;
      arvalid <= 1'b1;
      n = 0;
      @(negedge clk);
      while (!arready && n < TIMEOUT) begin
         n++;
         @(negedge clk);
      end
      if (n >= TIMEOUT) report_timeout("arready");
      @(posedge clk);
      arvalid <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!rvalid && n < TIMEOUT) begin
         n++;
         @(negedge clk);
      end
      if (n >= TIMEOUT) report_timeout("rvalid");
      @(posedge clk);
      rready <= 1'b1;   // accept the response one cycle late
      @(negedge clk);
      data = rdata;
      rsp = rresp;
      @(posedge clk);
      rready <= 1'b0;
   endtask

   task axi_write(input logic [AW-1:0] addr, output logic [1:0] rsp);
      int n;
      @(posedge clk);
      awaddr <= addr;
      awvalid <= 1'b1;
      wdata <= 32'h1;
      wvalid <= 1'b1;
      n = 0;
      @(negedge clk);
      while (!(awready && wready) && n < TIMEOUT) begin
         n++;
         @(negedge clk);
      end
      if (n >= TIMEOUT) report_timeout("awready and wready");
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!bvalid && n < TIMEOUT) begin
         n++;
         @(negedge clk);
      end
      if (n >= TIMEOUT) report_timeout("bvalid");
      @(posedge clk);
      bready <= 1'b1;   // accept the response one cycle late
      @(negedge clk);
      rsp = bresp;
      @(posedge clk);
      bready <= 1'b0;
   endtask

   // each packet belongs to the channel named by its first beat
   task load_expected();
      logic [SEL_W-1:0] ch;
      ch = '0;
      for (int i = 1; i <= num_beats; i++) begin
         if (testdata[i][DATA_W+8]) ch = testdata[i][SEL_W-1:0];
         exp_q[ch].push_back(testdata[i]);
      end
   endtask

   task send_packets();
      int n;
      @(posedge clk);
      for (int i = 1; i <= num_beats; i++) begin
         in_valid <= 1'b1;
         in_sop <= testdata[i][DATA_W+8];
         in_eop <= testdata[i][DATA_W+4];
         in_empty <= testdata[i][DATA_W+EW-1:DATA_W];
         in_data <= testdata[i][DATA_W-1:0];
         n = 0;
         @(negedge clk);
         while (!in_ready && n < TIMEOUT) begin
            n++;
            @(negedge clk);
         end
         if (n >= TIMEOUT) report_timeout("in_ready");
         @(posedge clk);
         beats_sent++;
      end
      in_valid <= 1'b0;
   endtask

   task collect_output();
      logic [SEL_W-1:0] out_ch;
      logic [REC_W-1:0] exp;
      int               n;
      out_ch = '0;
      while (beats_rcvd < num_beats) begin
         n = 0;
         @(negedge clk);
         while (!(out_valid && out_ready) && n < TIMEOUT) begin
            n++;
            @(negedge clk);
         end
         if (n >= TIMEOUT) report_timeout("an output beat");
         if (out_sop) out_ch = out_data[SEL_W-1:0];
         if (exp_q[out_ch].size() == 0) begin
            err_other++;
            $display("output beat %0d on channel %0d where no beat was expected",
                     beats_rcvd, out_ch);
         end else begin
            exp = exp_q[out_ch].pop_front();
            check_beat($sformatf("ch%0d output beat %0d", out_ch, beats_rcvd),
                       exp[DATA_W-1:0], exp[DATA_W+8], exp[DATA_W+4],
                       exp[DATA_W+EW-1:DATA_W], out_data, out_sop, out_eop, out_empty);
         end
         beats_rcvd++;
      end
   endtask

   task check_idle();
      @(negedge clk);
      if (out_valid) begin
         err_other++;
         $display("out_valid_o is high after reset");
      end
      if (bvalid || rvalid) begin
         err_other++;
         $display("a register bus response is pending after reset");
      end
   endtask

   task check_drained();
      repeat (3) @(negedge clk);
      if (out_valid) begin
         err_other++;
         $display("output stream still shows a beat after all packets arrived");
      end
      for (int ch = 0; ch < NUM_CH; ch++) begin
         if (exp_q[ch].size() != 0) begin
            err_other++;
            $display("channel %0d never delivered %0d beats", ch, exp_q[ch].size());
         end
      end
   endtask

   task check_counters(input string tag, input logic from_file);
      logic [DW-1:0] data;
      logic [1:0]    rsp;
      logic [CW-1:0] exp_pkt;
      logic [CW-1:0] exp_beat;
      for (int ch = 0; ch < NUM_CH; ch++) begin
         exp_pkt = from_file ? testdata[CNT_BASE+ch][2*CW-1:CW] : '0;
         exp_beat = from_file ? testdata[CNT_BASE+ch][CW-1:0] : '0;
         axi_read(AW'(ch * stats_pkg::REG_CH_STRIDE), data, rsp);
         check_count($sformatf("%s ch%0d packets", tag, ch), exp_pkt, CW'(data));
         check_resp($sformatf("%s ch%0d packet read", tag, ch), stats_pkg::RESP_OKAY, rsp);
         axi_read(AW'(ch * stats_pkg::REG_CH_STRIDE + 4), data, rsp);
         check_count($sformatf("%s ch%0d beats", tag, ch), exp_beat, CW'(data));
         check_resp($sformatf("%s ch%0d beat read", tag, ch), stats_pkg::RESP_OKAY, rsp);
      end
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      in_valid = 1'b0;
      in_data = '0;
      in_sop = 1'b0;
      in_eop = 1'b0;
      in_empty = '0;
      out_ready = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      seed = 54653;
      beats_sent = 0;
      beats_rcvd = 0;
      err_value = 0;
      err_other = 0;
      $readmemh("dv/pkt_testdata.txt", testdata);
      num_beats = int'(testdata[0][15:0]);
      load_expected();
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      check_idle();
      check_counters("after reset", 1'b0);

      fork
         send_packets();
         collect_output();
      join
      check_drained();
      check_counters("after traffic", 1'b1);

      axi_write(stats_pkg::REG_CLEAR, resp);
      check_resp("clear write", stats_pkg::RESP_OKAY, resp);
      check_counters("after clear", 1'b0);
      axi_read(UNMAPPED, rd_data, resp);
      check_count("unmapped read data", '0, CW'(rd_data));
      check_resp("unmapped read", stats_pkg::RESP_SLVERR, resp);

      finish_run();
   end

endmodule

// File: dv/pkt_testdata.txt
// word 0: beat count, then one beat per word as sop_eop_empty_data (hex)
// from @30: per channel, packets in the upper 32 bits and beats in the lower 32 bits
00c
1_0_0_0a0a0a0a0a0a0a00
0_1_3_0a0a0a0a0a0a0a01
1_0_0_1b1b1b1b1b1b1b01
0_0_0_1b1b1b1b1b1b1b02
0_1_5_1b1b1b1b1b1b1b03
1_1_2_2c2c2c2c2c2c2c02
1_0_0_3d3d3d3d3d3d3d04
0_1_0_3d3d3d3d3d3d3d05
1_0_0_4e4e4e4e4e4e4e07
0_1_7_4e4e4e4e4e4e4e08
1_0_0_5f5f5f5f5f5f5f05
0_1_1_5f5f5f5f5f5f5f06
@30
0000000200000004
0000000200000005
0000000100000001
0000000100000002

// File: verilog.f
rtl/pkt_stream_pkg.sv
rtl/stats_pkg.sv
rtl/pkt_dispatch.sv
rtl/channel_fifo.sv
rtl/pkt_merge.sv
rtl/stats_regs.sv
rtl/pkt_stats_top.sv
dv/pkt_stats_checker.sv
dv/tb_pkt_stats.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_pkt_stats
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := NO ERRORS
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
